// File: fft_post_proc.f
+incdir+rtl
rtl/fft_pp_ctrl_pkg.sv
rtl/fft_pp_data_pkg.sv
rtl/fft_settings_decode.sv
rtl/mag_execute.sv
rtl/round_clip_result.sv
rtl/fft_post_proc.sv
testbench/tb_clk_gen.sv
testbench/tb_fft_post_proc.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 \
  -f fft_post_proc.f --top-module tb_fft_post_proc \
  -Mdir obj_dir -o sim_fft_post_proc \
  && ./obj_dir/sim_fft_post_proc | tee /dev/stderr | grep -q "^TEST PASSED$" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: testbench/tb_fft_post_proc.sv
// Directed tests for the post-FFT path; a mode write must complete before the samples it affects

`include "fft_pp_params.svh"

`timescale 1ns/100ps
`default_nettype none

module tb_fft_post_proc;

  import fft_pp_data_pkg::*;

  localparam int          WAIT_LIMIT = 200;
  localparam logic [7:0]  ADDR_RESET = 8'(`FFT_PP_SR_RESET);
  localparam logic [7:0]  ADDR_MODE  = 8'(`FFT_PP_SR_MAG_OUT);
  localparam logic [63:0] RB_FILLER  = 64'h0BAD_C0DE_0BAD_C0DE;

  logic        ce_clk;
  logic        rst_n;
  logic        set_stb;
  logic [7:0]  set_addr;
  logic [31:0] set_data;
  logic [2:0]  rb_addr;
  logic [63:0] rb_data;
  logic        in_valid;
  sample_t     in_data;
  logic        in_ready;
  logic        out_valid;
  logic [31:0] out_data;
  logic        out_ready;

  logic        bp_en;
  logic        check_latency;
  logic [1:0]  cur_mode;
  logic [31:0] rng_state;
  logic [31:0] bp_state;
  logic [31:0] exp_q[$];
  int          in_cyc_q[$];
  logic [31:0] exp_word;
  int          in_cyc;
  int          cyc = 0;
  int          errors;
  int          compared;
  int          accepted;
  int          dropped;

  tb_clk_gen u_clk_gen (
    .o_clk   (ce_clk),
    .o_rst_n (rst_n)
  );

  fft_post_proc u_fft_post_proc (
    .ce_clk      (ce_clk),
    .i_rst_n     (rst_n),
    .i_set_stb   (set_stb),
    .i_set_addr  (set_addr),
    .i_set_data  (set_data),
    .i_rb_addr   (rb_addr),
    .o_rb_data   (rb_data),
    .i_in_valid  (in_valid),
    .i_in_data   (in_data),
    .o_in_ready  (in_ready),
    .o_out_valid (out_valid),
    .o_out_data  (out_data),
    .i_out_ready (out_ready)
  );

  // --------------------------------------------------------------------------
  // Reference model and random source
  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] v;
    v = x ^ (x << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Output word for one sample under the given mode
  function automatic logic [31:0] model_word(input logic [1:0] mode, input sample_t s);
    longint ai;
    longint aq;
    longint mx;
    longint mn;
    longint val;
    ai = longint'(s.i);
    aq = longint'(s.q);
    if (ai < 0) ai = -ai;
    if (aq < 0) aq = -aq;
    mx = (ai > aq) ? ai : aq;
    mn = (ai > aq) ? aq : ai;
    case (mode)
      2'd1: val = mx + mn / 2;
      2'd2: val = (ai * ai + aq * aq + 16384) / 32768;
      default: return {s.i, s.q};
    endcase
    if (val > 32767) val = 32767;
    return {val[15:0], 16'h0000};
  endfunction

  function automatic sample_t make_sample(input int i_val, input int q_val);
    sample_t s;
    s.i = 16'(i_val);
    s.q = 16'(q_val);
    return s;
  endfunction

  task automatic next_sample(input int shift, output sample_t s);
    rng_state = xorshift32(rng_state);
    s.i = $signed(rng_state[31:16]) >>> shift;
    s.q = $signed(rng_state[15:0]) >>> shift;
  endtask

  // --------------------------------------------------------------------------
  // Monitor, sampled mid-cycle where both sides are settled
  // --------------------------------------------------------------------------
  always @(posedge ce_clk) cyc <= cyc + 1;

  always @(negedge ce_clk) begin
    if (rst_n && in_valid && in_ready) begin
      exp_q.push_back(model_word(cur_mode, in_data));
      in_cyc_q.push_back(cyc + 1);
      accepted++;
    end
    if (rst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("Time %0t: output word 0x%08h appeared with nothing outstanding",
                 $time, out_data);
        errors++;
      end else begin
        exp_word = exp_q.pop_front();
        in_cyc   = in_cyc_q.pop_front();
        compared++;
        if (out_data !== exp_word) begin
          $display("[ERROR] %0t o_out_data expected 0x%08h actual 0x%08h",
                   $time, exp_word, out_data);
          errors++;
        end
        if (check_latency && (cyc + 1 - in_cyc) != 2) begin
          $display("[ERROR] %0t o_out_valid latency expected 2 actual %0d",
                   $time, cyc + 1 - in_cyc);
          errors++;
        end
      end
    end
  end

  // Random output stall, one decision per cycle
  always @(posedge ce_clk) begin
    if (bp_en) begin
      #1;
      bp_state  = xorshift32(bp_state);
      out_ready = bp_state[4];
    end
  end

  // --------------------------------------------------------------------------
  // Bus helpers, each entered and left 1 ns after a rising edge
  // --------------------------------------------------------------------------
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    set_stb  = 1'b1;
    set_addr = addr;
    set_data = data;
    @(posedge ce_clk);
    #1;
    set_stb = 1'b0;
    if (addr == ADDR_MODE) cur_mode = data[1:0];
  endtask

  task automatic check_rb(input logic [2:0] addr, input logic [63:0] expected);
    rb_addr = addr;
    @(negedge ce_clk);
    if (rb_data !== expected) begin
      $display("[ERROR] %0t o_rb_data at address %0d expected 0x%016h actual 0x%016h",
               $time, addr, expected, rb_data);
      errors++;
    end
    @(posedge ce_clk);
    #1;
  endtask

  task automatic send_sample(input sample_t s);
    int waited;
    waited   = 0;
    in_valid = 1'b1;
    in_data  = s;
    @(negedge ce_clk);
    while (!in_ready && waited < WAIT_LIMIT) begin
      @(negedge ce_clk);
      waited++;
    end
    if (!in_ready) begin
      $display("Time %0t: o_in_ready stayed low, a sample could not be sent", $time);
      errors++;
    end
    @(posedge ce_clk);
    #1;
  endtask

  task automatic stop_input();
    in_valid = 1'b0;
    in_data  = '0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge ce_clk);
      #1;
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Time %0t: pipeline did not drain, %0d items still outstanding",
               $time, exp_q.size());
      errors++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic reset_and_readback();
    if (out_valid !== 1'b0) begin
      $display("[ERROR] %0t o_out_valid expected 0 actual %b", $time, out_valid);
      errors++;
    end
    if (in_ready !== 1'b1) begin
      $display("[ERROR] %0t o_in_ready expected 1 actual %b", $time, in_ready);
      errors++;
    end
    check_rb(3'd0, 64'd0);
    check_rb(3'd1, 64'd0);
    check_rb(3'd5, RB_FILLER);
    write_reg(ADDR_MODE, 32'd2);
    check_rb(3'd1, 64'd2);
  endtask

  task automatic complex_passthrough();
    sample_t s;
    write_reg(ADDR_MODE, 32'd0);
    check_latency = 1'b1;
    for (int k = 0; k < 20; k++) begin
      next_sample(0, s);
      send_sample(s);
    end
    stop_input();
    wait_drain();
    check_latency = 1'b0;
  endtask

  task automatic approx_magnitude();
    sample_t s;
    write_reg(ADDR_MODE, 32'd1);
    send_sample(make_sample(-32768, -32768));
    send_sample(make_sample(0, 0));
    send_sample(make_sample(32767, -32768));
    send_sample(make_sample(-3, 10));
    for (int k = 0; k < 24; k++) begin
      next_sample(k % 9, s);
      send_sample(s);
    end
    stop_input();
    wait_drain();
  endtask

  task automatic squared_magnitude();
    sample_t s;
    write_reg(ADDR_MODE, 32'd2);
    send_sample(make_sample(-32768, -32768));
    send_sample(make_sample(128, 0));
    send_sample(make_sample(127, 0));
    send_sample(make_sample(0, 181));
    send_sample(make_sample(-23170, 23170));
    send_sample(make_sample(23171, 23171));
    for (int k = 0; k < 24; k++) begin
      next_sample(k % 9, s);
      send_sample(s);
    end
    stop_input();
    wait_drain();
  endtask

  task automatic back_pressure_stream();
    sample_t s;
    write_reg(ADDR_MODE, 32'd0);
    bp_en = 1'b1;
    for (int k = 0; k < 50; k++) begin
      next_sample(0, s);
      send_sample(s);
    end
    stop_input();
    wait_drain();
    bp_en = 1'b0;
    @(posedge ce_clk);
    #1;
    out_ready = 1'b1;
  endtask

  task automatic soft_reset_flush();
    sample_t s;
    int      waited;
    write_reg(ADDR_MODE, 32'd1);
    out_ready = 1'b0;
    // Two items fill both stages while the output is stalled
    next_sample(2, s);
    send_sample(s);
    next_sample(2, s);
    send_sample(s);
    stop_input();
    write_reg(ADDR_RESET, 32'd1);
    waited = 0;
    @(negedge ce_clk);
    while ((out_valid || in_ready) && waited < 2) begin
      @(negedge ce_clk);
      waited++;
    end
    if (out_valid || in_ready) begin
      $display("Time %0t: pipeline did not clear within two cycles of soft reset", $time);
      errors++;
    end
    @(posedge ce_clk);
    #1;
    dropped += exp_q.size();
    exp_q.delete();
    in_cyc_q.delete();
    out_ready = 1'b1;
    check_rb(3'd0, 64'd1);
    repeat (4) begin
      @(negedge ce_clk);
      if (out_valid !== 1'b0) begin
        $display("[ERROR] %0t o_out_valid expected 0 actual %b", $time, out_valid);
        errors++;
      end
      if (in_ready !== 1'b0) begin
        $display("[ERROR] %0t o_in_ready expected 0 actual %b", $time, in_ready);
        errors++;
      end
    end
    @(posedge ce_clk);
    #1;
    write_reg(ADDR_RESET, 32'd0);
    for (int k = 0; k < 10; k++) begin
      next_sample(3, s);
      send_sample(s);
    end
    stop_input();
    wait_drain();
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    int waited;
    set_stb       = 1'b0;
    set_addr      = '0;
    set_data      = '0;
    rb_addr       = '0;
    in_valid      = 1'b0;
    in_data       = '0;
    out_ready     = 1'b1;
    bp_en         = 1'b0;
    check_latency = 1'b0;
    cur_mode      = 2'd0;
    rng_state     = 32'd10;
    bp_state      = 32'd10;
    errors        = 0;
    compared      = 0;
    accepted      = 0;
    dropped       = 0;
    waited        = 0;

    while (rst_n !== 1'b1 && waited < WAIT_LIMIT) begin
      @(posedge ce_clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("Time %0t: reset was never released", $time);
      errors++;
    end
    @(posedge ce_clk);
    #1;

    reset_and_readback();
    complex_passthrough();
    approx_magnitude();
    squared_magnitude();
    back_pressure_stream();
    soft_reset_flush();

    if (compared + dropped != accepted) begin
      $display("Time %0t: %0d samples accepted but %0d compared and %0d flushed",
               $time, accepted, compared, dropped);
      errors++;
    end
    $display("Checks: %0d outputs compared, %0d flushed, %0d errors",
             compared, dropped, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Hard limit on simulated time
  initial begin
    #200_000;
    $display("Simulation time limit reached before the tests finished");
    $display("Checks: %0d outputs compared, %0d errors", compared, errors);
    $display("TEST FAILED");
    $finish;
  end

endmodule : tb_fft_post_proc

`default_nettype wire

// File: testbench/tb_clk_gen.sv
// Free-running 8 ns clock; reset is low for the first two rising edges and released 1 ns later

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #4 o_clk = ~o_clk;
  end

  // Release off the edge so no flop sees it change at a clock
  initial begin
    o_rst_n = 1'b0;
    repeat (2) @(posedge o_clk);
    #1 o_rst_n = 1'b1;
  end

endmodule : tb_clk_gen

`default_nettype wire

// File: rtl/fft_post_proc.sv
// Post-FFT output path with two-cycle latency; mode is sampled per item at the input

`include "fft_pp_params.svh"

`timescale 1ns/100ps
`default_nettype none

module fft_post_proc (
  input  wire                              ce_clk,
  input  wire                              i_rst_n,
  // Settings bus and readback
  input  wire                              i_set_stb,
  input  wire  [`FFT_PP_SET_AW-1:0]        i_set_addr,
  input  wire  [31:0]                      i_set_data,
  input  wire  [`FFT_PP_RB_AW-1:0]         i_rb_addr,
  output logic [`FFT_PP_RB_W-1:0]          o_rb_data,
  // Sample stream in
  input  wire                              i_in_valid,
  input  wire fft_pp_data_pkg::sample_t    i_in_data,
  output logic                             o_in_ready,
  // Sample stream out
  output logic                             o_out_valid,
  output logic [`FFT_PP_WORD_W-1:0]        o_out_data,
  input  wire                              i_out_ready
);

  fft_pp_ctrl_pkg::ctrl_regs_t    regs;
  logic                           exec_valid;
  logic                           exec_ready;
  fft_pp_data_pkg::exec_payload_t exec_payload;

  // ---------------------------------------------------------------------------
  // Register bank
  // ---------------------------------------------------------------------------
  fft_settings_decode u_decode (
    .ce_clk     (ce_clk),
    .i_rst_n    (i_rst_n),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .i_rb_addr  (i_rb_addr),
    .o_rb_data  (o_rb_data),
    .o_regs     (regs)
  );

  // ---------------------------------------------------------------------------
  // Two-stage pipeline
  // ---------------------------------------------------------------------------
  mag_execute u_execute (
    .ce_clk    (ce_clk),
    .i_rst_n   (i_rst_n),
    .i_regs    (regs),
    .i_valid   (i_in_valid),
    .i_data    (i_in_data),
    .o_ready   (o_in_ready),
    .o_valid   (exec_valid),
    .o_payload (exec_payload),
    .i_ready   (exec_ready)
  );

  round_clip_result u_result (
    .ce_clk     (ce_clk),
    .i_rst_n    (i_rst_n),
    .i_soft_rst (regs.soft_rst),
    .i_valid    (exec_valid),
    .i_payload  (exec_payload),
    .o_ready    (exec_ready),
    .o_valid    (o_out_valid),
    .o_data     (o_out_data),
    .i_ready    (i_out_ready)
  );

endmodule : fft_post_proc

`default_nettype wire

// File: rtl/round_clip_result.sv
// Second stage; magnitude modes give an unsigned 15-bit value in the upper half only

`include "fft_pp_params.svh"

`timescale 1ns/100ps
`default_nettype none

module round_clip_result (
  input  wire                                  ce_clk,
  input  wire                                  i_rst_n,
  input  wire                                  i_soft_rst,
  input  wire                                  i_valid,
  input  wire fft_pp_data_pkg::exec_payload_t  i_payload,
  output logic                                 o_ready,
  output logic                                 o_valid,
  output logic [`FFT_PP_WORD_W-1:0]            o_data,
  input  wire                                  i_ready
);

  import fft_pp_ctrl_pkg::*;
  import fft_pp_data_pkg::*;

  localparam int SW = `FFT_PP_SAMPLE_W;

  // Rounding constant for the shift by SW-1
  localparam logic [2*SW:0] SQ_HALF = (2*SW+1)'(1) << (SW-2);

  logic                      valid_r;
  logic [`FFT_PP_WORD_W-1:0] data_r;
  logic [`FFT_PP_WORD_W-1:0] data_nxt;
  logic [2*SW:0]             sq_rounded;
  logic [SW+1:0]             sq_scaled;

  // Saturate to the largest positive 16-bit value
  function automatic logic [SW-1:0] clip_pos(input logic [SW+1:0] v);
    logic [SW+1:0] lim;
    lim = (SW+2)'(2**(SW-1) - 1);
    if (v > lim) begin
      return lim[SW-1:0];
    end
    return v[SW-1:0];
  endfunction

  // ---------------------------------------------------------------------------
  // Mode select, rounding and clipping
  // ---------------------------------------------------------------------------
  always_comb begin
    // Round half up, then drop the SW-1 fraction bits
    sq_rounded = {1'b0, i_payload.mag_sq} + SQ_HALF;
    sq_scaled  = sq_rounded[2*SW:SW-1];

    case (i_payload.mode)
      MODE_MAG: begin
        data_nxt = {clip_pos({1'b0, i_payload.mag_approx}), {SW{1'b0}}};
      end
      MODE_MAG_SQ: begin
        data_nxt = {clip_pos(sq_scaled), {SW{1'b0}}};
      end
      // Complex and reserved pass the sample as is
      default: begin
        data_nxt = i_payload.raw;
      end
    endcase
  end

  // ---------------------------------------------------------------------------
  // Handshake and output register
  // ---------------------------------------------------------------------------
  assign o_ready = !i_soft_rst && (!valid_r || i_ready);

  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_r <= 1'b0;
    end else if (i_soft_rst) begin
      valid_r <= 1'b0;
    end else if (o_ready) begin
      valid_r <= i_valid;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_valid && o_ready) begin
      data_r <= data_nxt;
    end
  end

  assign o_valid = valid_r;
  assign o_data  = data_r;

  // Output word waits unchanged for the consumer
  a_result_hold: assert property (
    @(posedge ce_clk) disable iff (!i_rst_n)
    (o_valid && !i_ready && !i_soft_rst) |=> (o_valid && $stable(o_data))
  ) else $error("result output changed while stalled");

endmodule : round_clip_result

`default_nettype wire

// File: rtl/mag_execute.sv
// First stage holds one item; soft reset drops it and blocks input until released

`include "fft_pp_params.svh"

`timescale 1ns/100ps
`default_nettype none

module mag_execute (
  input  wire                                ce_clk,
  input  wire                                i_rst_n,
  input  wire fft_pp_ctrl_pkg::ctrl_regs_t   i_regs,
  input  wire                                i_valid,
  input  wire fft_pp_data_pkg::sample_t      i_data,
  output logic                               o_ready,
  output logic                               o_valid,
  output fft_pp_data_pkg::exec_payload_t     o_payload,
  input  wire                                i_ready
);

  import fft_pp_ctrl_pkg::*;
  import fft_pp_data_pkg::*;

  localparam int SW = `FFT_PP_SAMPLE_W;

  logic                   valid_r;
  exec_payload_t          payload_r;
  exec_payload_t          payload_nxt;
  logic                   accept;

  logic signed [SW:0]     i_ext;
  logic signed [SW:0]     q_ext;
  logic        [SW:0]     abs_i;
  logic        [SW:0]     abs_q;
  logic        [SW:0]     mag_max;
  logic        [SW:0]     mag_min;
  logic        [2*SW-1:0] sq_i;
  logic        [2*SW-1:0] sq_q;

  // ---------------------------------------------------------------------------
  // Arithmetic on the incoming sample
  // ---------------------------------------------------------------------------
  always_comb begin
    // One extra bit so that -32768 has a representable absolute value
    i_ext = {i_data.i[SW-1], i_data.i};
    q_ext = {i_data.q[SW-1], i_data.q};
    abs_i = i_ext[SW] ? -i_ext : i_ext;
    abs_q = q_ext[SW] ? -q_ext : q_ext;

    if (abs_i >= abs_q) begin
      mag_max = abs_i;
      mag_min = abs_q;
    end else begin
      mag_max = abs_q;
      mag_min = abs_i;
    end

    // Squares of the absolute values, each at most 2^30
    sq_i = {{(SW-1){1'b0}}, abs_i} * {{(SW-1){1'b0}}, abs_i};
    sq_q = {{(SW-1){1'b0}}, abs_q} * {{(SW-1){1'b0}}, abs_q};

    payload_nxt.mode       = i_regs.mode;
    payload_nxt.raw        = i_data;
    payload_nxt.mag_approx = mag_max + {1'b0, mag_min[SW:1]};
    payload_nxt.mag_sq     = sq_i + sq_q;
  end

  // ---------------------------------------------------------------------------
  // Handshake and output register
  // ---------------------------------------------------------------------------
  assign o_ready = !i_regs.soft_rst && (!valid_r || i_ready);
  assign accept  = i_valid && o_ready;

  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_r <= 1'b0;
    end else if (i_regs.soft_rst) begin
      valid_r <= 1'b0;
    end else if (o_ready) begin
      valid_r <= i_valid;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (accept) begin
      payload_r <= payload_nxt;
    end
  end

  assign o_valid   = valid_r;
  assign o_payload = payload_r;

  // Stalled item is neither dropped nor altered
  a_exec_hold: assert property (
    @(posedge ce_clk) disable iff (!i_rst_n)
    (o_valid && !i_ready && !i_regs.soft_rst) |=> (o_valid && $stable(o_payload))
  ) else $error("execute output changed while stalled");

endmodule : mag_execute

`default_nettype wire

// File: rtl/fft_settings_decode.sv
// Register bank on the settings strobe bus; only addresses 131 and 133 are writable

`include "fft_pp_params.svh"

`timescale 1ns/100ps
`default_nettype none

module fft_settings_decode (
  input  wire                               ce_clk,
  input  wire                               i_rst_n,
  input  wire                               i_set_stb,
  input  wire  [`FFT_PP_SET_AW-1:0]         i_set_addr,
  input  wire  [31:0]                       i_set_data,
  input  wire  [`FFT_PP_RB_AW-1:0]          i_rb_addr,
  output logic [`FFT_PP_RB_W-1:0]           o_rb_data,
  output fft_pp_ctrl_pkg::ctrl_regs_t       o_regs
);

  import fft_pp_ctrl_pkg::*;

  localparam logic [`FFT_PP_SET_AW-1:0] SR_RESET_ADDR = `FFT_PP_SET_AW'(`FFT_PP_SR_RESET);
  localparam logic [`FFT_PP_SET_AW-1:0] SR_MODE_ADDR  = `FFT_PP_SET_AW'(`FFT_PP_SR_MAG_OUT);

  ctrl_regs_t regs_r;
  logic       wr_reset;
  logic       wr_mode;

  // ---------------------------------------------------------------------------
  // Write decode
  // ---------------------------------------------------------------------------
  assign wr_reset = i_set_stb && (i_set_addr == SR_RESET_ADDR);
  assign wr_mode  = i_set_stb && (i_set_addr == SR_MODE_ADDR);

  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      regs_r.soft_rst <= 1'b0;
      regs_r.mode     <= MODE_COMPLEX;
    end else begin
      if (wr_reset) begin
        regs_r.soft_rst <= i_set_data[0];
      end
      // Reserved code 3 is stored as written
      if (wr_mode) begin
        regs_r.mode <= out_mode_e'(i_set_data[1:0]);
      end
    end
  end

  assign o_regs = regs_r;

  // ---------------------------------------------------------------------------
  // Readback, combinational on the address
  // ---------------------------------------------------------------------------
  always_comb begin
    case (i_rb_addr)
      `FFT_PP_RB_AW'(0): o_rb_data = `FFT_PP_RB_W'(regs_r.soft_rst);
      `FFT_PP_RB_AW'(1): o_rb_data = `FFT_PP_RB_W'(regs_r.mode);
      default:           o_rb_data = `FFT_PP_RB_BAD;
    endcase
  end

  // ---------------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------------

  // Mode moves only as the result of a write to its own address
  a_mode_by_write: assert property (
    @(posedge ce_clk) disable iff (!i_rst_n)
    $changed(regs_r.mode) |-> $past(wr_mode)
  ) else $error("mode changed without a settings write to its address");

endmodule : fft_settings_decode

`default_nettype wire

// File: rtl/fft_pp_data_pkg.sv
// Data path types; compile after fft_pp_ctrl_pkg since the stage payload carries the mode

`include "fft_pp_params.svh"

`default_nettype none

package fft_pp_data_pkg;

  // -------------------------------------------------------------------------
  // Complex sample, I packed above Q
  // -------------------------------------------------------------------------
  typedef struct packed {
    logic signed [`FFT_PP_SAMPLE_W-1:0] i;
    logic signed [`FFT_PP_SAMPLE_W-1:0] q;
  } sample_t;

  // -------------------------------------------------------------------------
  // Payload from execute to result
  // -------------------------------------------------------------------------
  typedef struct packed {
    // Mode in force when the sample was accepted
    fft_pp_ctrl_pkg::out_mode_e mode;
    sample_t                    raw;
    // max(|I|,|Q|) + min(|I|,|Q|)/2, one bit wider than a component
    logic [`FFT_PP_SAMPLE_W:0]     mag_approx;
    // I*I + Q*Q, never above 2^31
    logic [2*`FFT_PP_SAMPLE_W-1:0] mag_sq;
  } exec_payload_t;

endpackage : fft_pp_data_pkg

`default_nettype wire

// File: rtl/fft_pp_ctrl_pkg.sv
// Control types for the post-FFT path; mode 3 is reserved and treated as complex

`default_nettype none

package fft_pp_ctrl_pkg;

  // -------------------------------------------------------------------------
  // Output mode, as written to the magnitude register
  // -------------------------------------------------------------------------
  typedef enum logic [1:0] {
    MODE_COMPLEX = 2'd0,
    MODE_MAG     = 2'd1,
    MODE_MAG_SQ  = 2'd2,
    MODE_RSVD    = 2'd3
  } out_mode_e;

  // -------------------------------------------------------------------------
  // Register bank seen by both pipeline stages
  // -------------------------------------------------------------------------
  typedef struct packed {
    // Holds both stages empty while set
    logic      soft_rst;
    out_mode_e mode;
  } ctrl_regs_t;

endpackage : fft_pp_ctrl_pkg

`default_nettype wire

// File: rtl/fft_pp_params.svh
// Widths and register map for the post-FFT path assume 16-bit I/Q and an 8-bit settings bus

`ifndef FFT_PP_PARAMS_SVH
`define FFT_PP_PARAMS_SVH

// ---------------------------------------------------------------------------
// Data path widths
// ---------------------------------------------------------------------------

// One I or Q component
`define FFT_PP_SAMPLE_W 16

// Stream word, I in the upper half
`define FFT_PP_WORD_W 32

// ---------------------------------------------------------------------------
// Settings bus and readback
// ---------------------------------------------------------------------------

`define FFT_PP_SET_AW 8
`define FFT_PP_RB_AW  3
`define FFT_PP_RB_W   64

// Settings register addresses
`define FFT_PP_SR_RESET   131
`define FFT_PP_SR_MAG_OUT 133

// Returned for unused readback addresses
`define FFT_PP_RB_BAD 64'h0BAD_C0DE_0BAD_C0DE

`endif
